// ==== include/emesh_cfg.svh ====
`ifndef EMESH_CFG_SVH
`define EMESH_CFG_SVH

// Packet layout from bit 0 upward:
// write(1) datamode(2) ctrlmode(4) spare(1) dstaddr(32) data(32) srcaddr(32)
`define EMESH_PW       104         // Flat packet width
`define EMESH_AW       32          // Address field width
`define EMESH_DW       32          // Data field width

`define EMESH_MEM_AW   8           // Word address bits, 256 words
`define EMESH_FIFO_AW  2           // Queue depth exponent, 4 entries

// Field offsets inside the packet
`define EMESH_WR_BIT   0           // Write flag
`define EMESH_DM_LSB   1           // Datamode
`define EMESH_CM_LSB   3           // Ctrlmode
`define EMESH_DST_LSB  8           // Destination address
`define EMESH_DAT_LSB  40          // Data
`define EMESH_SRC_LSB  72          // Source address

`endif

// ==== verilog/emesh_pkg.sv ====
`default_nettype none

package emesh_pkg;

   //##########################################################################
   // Request fields
   //##########################################################################

   // Opcode lives in the packet's write flag
   typedef enum logic {
      OP_READ  = 1'b0,                 // Read request, returns a response
      OP_WRITE = 1'b1                  // Write request, no response
   } emesh_op_e;

   // Access size
   typedef enum logic [1:0] {
      DMODE_BYTE   = 2'b00,            // 8 bit lane
      DMODE_HALF   = 2'b01,            // 16 bit lane, addr bit 1 picks half
      DMODE_WORD   = 2'b10,            // Whole 32 bit word
      DMODE_DOUBLE = 2'b11             // 64 bit, not supported here
   } emesh_dmode_e;

   //##########################################################################
   // Arbiter
   //##########################################################################

   typedef enum logic [1:0] {
      ARB_IDLE  = 2'b00,               // Nothing granted
      ARB_WRITE = 2'b01,               // Write queue owns memory
      ARB_READ  = 2'b10                // Read queue owns memory
   } arb_state_e;

endpackage

`default_nettype wire

// ==== verilog/emesh_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "emesh_cfg.svh"

module emesh_decoder (
   // Request port from outside
   input  wire                   access_in,
   input  wire [`EMESH_PW-1:0]   packet_in,
   output logic                  wait_out,
   // Write queue side
   output logic                  wr_access,
   output logic [`EMESH_PW-1:0]  wr_packet,
   input  wire                   wr_wait,
   // Read queue side
   output logic                  rd_access,
   output logic [`EMESH_PW-1:0]  rd_packet,
   input  wire                   rd_wait
);

   import emesh_pkg::*;

   emesh_op_e op;                                        // Opcode of current packet

   assign op = emesh_op_e'(packet_in[`EMESH_WR_BIT]);    // Write flag is the opcode

   // Steer access to one channel only
   assign wr_access = access_in & (op == OP_WRITE);      // Writes to write queue
   assign rd_access = access_in & (op == OP_READ);       // Reads to read queue

   // Payload goes to both, access qualifies it
   assign wr_packet = packet_in;
   assign rd_packet = packet_in;

   // Back-pressure of the selected queue only, so a full read
   // queue never holds up a write and the other way round
   assign wait_out  = (op == OP_WRITE) ? wr_wait : rd_wait;

   // Request needs a known opcode so exactly one queue is picked
   always_comb begin
      if (access_in)
         assert (!$isunknown(packet_in[`EMESH_WR_BIT]))
            else $error("request with unknown opcode");  // Both queues would see X
   end

endmodule

`default_nettype wire

// ==== verilog/emesh_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "emesh_cfg.svh"

module emesh_fifo #(
   parameter int DEPTH_AW = `EMESH_FIFO_AW               // Log2 of entries
) (
   input  wire                   clk,
   input  wire                   rst,
   // Writer side
   input  wire                   access_in,
   input  wire [`EMESH_PW-1:0]   packet_in,
   output logic                  wait_out,
   // Reader side, head shown without delay
   output logic                  access_out,
   output logic [`EMESH_PW-1:0]  packet_out,
   input  wire                   wait_in
);

   localparam int DEPTH = 1 << DEPTH_AW;

   logic [`EMESH_PW-1:0] mem [DEPTH];                    // Entry storage
   logic [DEPTH_AW-1:0]  wr_ptr;                         // Next free slot
   logic [DEPTH_AW-1:0]  rd_ptr;                         // Head slot
   logic [DEPTH_AW:0]    count;                          // Occupancy
   logic                 full;
   logic                 push;
   logic                 pop;

   assign full       = (count == DEPTH[DEPTH_AW:0]);
   assign access_out = (count != '0);                    // Head valid
   assign packet_out = mem[rd_ptr];
   assign wait_out   = full & wait_in;                   // Full but draining is ok
   assign push       = access_in & ~wait_out;
   assign pop        = access_out & ~wait_in;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= packet_in;                       // Payload, no reset
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;                     // Wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // A writer held off by a full queue keeps its packet until taken
   assert property (@(posedge clk) disable iff (rst)
      (access_in && wait_out) |=> access_in && $stable(packet_in))
      else $error("writer dropped or changed a stalled packet");

endmodule

`default_nettype wire

// ==== verilog/emesh_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "emesh_cfg.svh"

module emesh_arbiter (
   input  wire                   clk,
   input  wire                   rst,
   // Write queue head
   input  wire                   wr_access,
   input  wire [`EMESH_PW-1:0]   wr_packet,
   output logic                  wr_wait,
   // Read queue head
   input  wire                   rd_access,
   input  wire [`EMESH_PW-1:0]   rd_packet,
   output logic                  rd_wait,
   // Shared memory port
   output logic                  mem_access,
   output logic [`EMESH_PW-1:0]  mem_packet,
   input  wire                   mem_wait
);

   import emesh_pkg::*;

   arb_state_e cur_grant;                                // Grant this cycle
   arb_state_e last_grant;                               // Grant of previous cycle
   logic       stall_q;                                  // Previous grant was stalled

   // Write first, but a stalled grant is kept so the packet stays put
   always_comb begin
      if (stall_q)
         cur_grant = last_grant;                         // Hold the owner
      else if (wr_access)
         cur_grant = ARB_WRITE;                          // Writes win
      else if (rd_access)
         cur_grant = ARB_READ;
      else
         cur_grant = ARB_IDLE;
   end

   assign mem_access = (cur_grant != ARB_IDLE);
   assign mem_packet = (cur_grant == ARB_READ) ? rd_packet : wr_packet;
   assign wr_wait    = mem_wait | (cur_grant == ARB_READ);  // Loser waits
   assign rd_wait    = mem_wait | (cur_grant == ARB_WRITE);

   always_ff @(posedge clk) begin
      if (rst) begin
         last_grant <= ARB_IDLE;
         stall_q    <= 1'b0;
      end else begin
         last_grant <= cur_grant;
         stall_q    <= mem_access & mem_wait;            // Not taken this edge
      end
   end

   // A stalled owner keeps its head and its payload on the next cycle
   assert property (@(posedge clk) disable iff (rst)
      (mem_access && mem_wait) |=>
         ((last_grant == ARB_READ) ? rd_access : wr_access) && $stable(mem_packet))
      else $error("granted packet changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/emesh_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "emesh_cfg.svh"

module emesh_memory (
   input  wire                   clk,
   input  wire                   rst,
   // Request port
   input  wire                   access_in,
   input  wire [`EMESH_PW-1:0]   packet_in,
   output logic                  wait_out,
   // Read response port
   output logic                  access_out,
   output logic [`EMESH_PW-1:0]  packet_out,
   input  wire                   wait_in
);

   import emesh_pkg::*;

   localparam int DEPTH = 1 << `EMESH_MEM_AW;

   //##########################################################################
   // Request decode
   //##########################################################################

   emesh_op_e             op;
   emesh_dmode_e          dmode;
   logic [3:0]            ctrlmode;
   logic [`EMESH_AW-1:0]  dstaddr;
   logic [`EMESH_DW-1:0]  data;
   logic [`EMESH_AW-1:0]  srcaddr;
   logic [`EMESH_MEM_AW-1:0] addr;                       // Word index, upper bits alias
   logic [3:0]            be;                            // Byte lane enables
   logic [`EMESH_DW-1:0]  wdata;                         // Data replicated over lanes
   logic                  accept;

   assign op       = emesh_op_e'(packet_in[`EMESH_WR_BIT]);
   assign dmode    = emesh_dmode_e'(packet_in[`EMESH_DM_LSB +: 2]);
   assign ctrlmode = packet_in[`EMESH_CM_LSB +: 4];
   assign dstaddr  = packet_in[`EMESH_DST_LSB +: `EMESH_AW];
   assign data     = packet_in[`EMESH_DAT_LSB +: `EMESH_DW];
   assign srcaddr  = packet_in[`EMESH_SRC_LSB +: `EMESH_AW];
   assign addr     = dstaddr[`EMESH_MEM_AW+1:2];

   always_comb begin
      case (dmode)
         DMODE_BYTE: begin
            be    = 4'b0001 << dstaddr[1:0];             // Lane from addr[1:0]
            wdata = {4{data[7:0]}};
         end
         DMODE_HALF: begin
            be    = dstaddr[1] ? 4'b1100 : 4'b0011;      // Addr bit 1 only
            wdata = {2{data[15:0]}};
         end
         DMODE_WORD: begin
            be    = 4'b1111;
            wdata = data;
         end
         default: begin
            be    = 4'b0000;                             // Double not stored
            wdata = data;
         end
      endcase
   end

   assign wait_out = access_out & wait_in;               // Held response stalls all
   assign accept   = access_in & ~wait_out;

   //##########################################################################
   // Storage and response
   //##########################################################################

   logic [`EMESH_DW-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (accept && op == OP_WRITE && be[i])
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];      // Stored on accept edge
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         access_out <= 1'b0;
      else if (accept && op == OP_READ)
         access_out <= 1'b1;                             // New response
      else if (!wait_in)
         access_out <= 1'b0;                             // Old one transferred
   end

   // Request and word captured together, addresses swapped
   always_ff @(posedge clk) begin
      if (accept && op == OP_READ)
         packet_out <= {dstaddr, mem[addr], srcaddr, 1'b0, ctrlmode,
                        DMODE_WORD, 1'b1};
   end

   assert property (@(posedge clk) disable iff (rst) accept |-> dmode != DMODE_DOUBLE)
      else $error("double access not supported");

endmodule

`default_nettype wire

// ==== verilog/emesh_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "emesh_cfg.svh"

module emesh_mem_top (
   input  wire                   clk,
   input  wire                   rst,
   // Request port
   input  wire                   access_in,
   input  wire [`EMESH_PW-1:0]   packet_in,
   output logic                  wait_out,
   // Read response port
   output logic                  access_out,
   output logic [`EMESH_PW-1:0]  packet_out,
   input  wire                   wait_in
);

   //##########################################################################
   // Internal links
   //##########################################################################

   logic                 dec_wr_access;                  // Decoder to write queue
   logic [`EMESH_PW-1:0] dec_wr_packet;
   logic                 dec_wr_wait;
   logic                 dec_rd_access;                  // Decoder to read queue
   logic [`EMESH_PW-1:0] dec_rd_packet;
   logic                 dec_rd_wait;
   logic                 wrq_access;                     // Write queue head
   logic [`EMESH_PW-1:0] wrq_packet;
   logic                 wrq_wait;
   logic                 rdq_access;                     // Read queue head
   logic [`EMESH_PW-1:0] rdq_packet;
   logic                 rdq_wait;
   logic                 mem_access;                     // Arbiter to memory
   logic [`EMESH_PW-1:0] mem_packet;
   logic                 mem_wait;

   emesh_decoder dec0 (
      .access_in (access_in),     .packet_in (packet_in),     .wait_out (wait_out),
      .wr_access (dec_wr_access), .wr_packet (dec_wr_packet), .wr_wait  (dec_wr_wait),
      .rd_access (dec_rd_access), .rd_packet (dec_rd_packet), .rd_wait  (dec_rd_wait)
   );

   emesh_fifo fifo_wr (
      .clk        (clk),           .rst        (rst),
      .access_in  (dec_wr_access), .packet_in  (dec_wr_packet), .wait_out (dec_wr_wait),
      .access_out (wrq_access),    .packet_out (wrq_packet),    .wait_in  (wrq_wait)
   );

   emesh_fifo fifo_rd (
      .clk        (clk),           .rst        (rst),
      .access_in  (dec_rd_access), .packet_in  (dec_rd_packet), .wait_out (dec_rd_wait),
      .access_out (rdq_access),    .packet_out (rdq_packet),    .wait_in  (rdq_wait)
   );

   emesh_arbiter arb0 (
      .clk        (clk),        .rst        (rst),
      .wr_access  (wrq_access), .wr_packet  (wrq_packet), .wr_wait  (wrq_wait),
      .rd_access  (rdq_access), .rd_packet  (rdq_packet), .rd_wait  (rdq_wait),
      .mem_access (mem_access), .mem_packet (mem_packet), .mem_wait (mem_wait)
   );

   emesh_memory mem0 (
      .clk        (clk),        .rst        (rst),
      .access_in  (mem_access), .packet_in  (mem_packet), .wait_out (mem_wait),
      .access_out (access_out), .packet_out (packet_out), .wait_in  (wait_in)
   );

endmodule

`default_nettype wire

// ==== sim/emesh_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "emesh_cfg.svh"

module emesh_mem_tb;

   import emesh_pkg::*;

   localparam int CLK_PERIOD  = 4;                       // ns
   localparam int TOTAL_PKTS  = 240;                     // Packets over all tests
   localparam int WDOG_CYCLES = TOTAL_PKTS * 50 + 500;   // Plus margin
   localparam int RSP_TIMEOUT = 2000;                    // Cycles to drain responses

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 access_in;
   logic [`EMESH_PW-1:0] packet_in;
   logic                 wait_out;
   logic                 access_out;
   logic [`EMESH_PW-1:0] packet_out;
   logic                 wait_in;

   logic [31:0]          model [int];                    // Reference words by index
   logic [`EMESH_PW-1:0] exp_q [$];                      // Responses still due, in order
   int                   pending [256] = '{default: 0};  // Reads in flight per word
   int                   seed = 98;
   logic                 rand_wait = 1'b0;               // Random wait_in while sending
   logic                 held = 1'b0;                    // Response stalled last edge
   logic [`EMESH_PW-1:0] held_pkt;
   int                   value_errors = 0;
   int                   other_errors = 0;
   int                   rsp_count = 0;

   always #(CLK_PERIOD/2) clk = ~clk;

   emesh_mem_top dut0 (
      .clk        (clk),        .rst        (rst),
      .access_in  (access_in),  .packet_in  (packet_in),  .wait_out (wait_out),
      .access_out (access_out), .packet_out (packet_out), .wait_in  (wait_in)
   );

   //##########################################################################
   // Reference model
   //##########################################################################

   function automatic int word_index(input logic [31:0] addr);
      return int'(addr[`EMESH_MEM_AW+1:2]);              // Upper bits alias
   endfunction

   function automatic logic [`EMESH_PW-1:0] make_packet(input logic wr,
      input logic [1:0] dmode, input logic [3:0] ctrl, input logic [31:0] dst,
      input logic [31:0] data, input logic [31:0] src);
      logic [`EMESH_PW-1:0] p;
      p = '0;                                            // Spare bit stays low
      p[`EMESH_WR_BIT]               = wr;
      p[`EMESH_DM_LSB +: 2]          = dmode;
      p[`EMESH_CM_LSB +: 4]          = ctrl;
      p[`EMESH_DST_LSB +: `EMESH_AW] = dst;
      p[`EMESH_DAT_LSB +: `EMESH_DW] = data;
      p[`EMESH_SRC_LSB +: `EMESH_AW] = src;
      return p;
   endfunction

   function automatic void model_write(input logic [31:0] addr,
      input emesh_dmode_e dmode, input logic [31:0] data);
      logic [31:0] w;
      w = model.exists(word_index(addr)) ? model[word_index(addr)] : 32'hx;
      case (dmode)
         DMODE_BYTE: w[8*addr[1:0] +: 8] = data[7:0];    // Lane from addr[1:0]
         DMODE_HALF: w[16*addr[1] +: 16] = data[15:0];   // Addr bit 1 only
         default:    w = data;
      endcase
      model[word_index(addr)] = w;
   endfunction

   //##########################################################################
   // Driver tasks, entered on a falling edge
   //##########################################################################

   task automatic send_packet(input logic [`EMESH_PW-1:0] pkt);
      logic done;
      done = 1'b0;
      while (!done) begin
         access_in = 1'b1;
         packet_in = pkt;                                // Held until taken
         if (rand_wait)
            wait_in = (($random(seed) & 3) == 0);        // Stall about one edge in four
         #1;
         done = !wait_out;                               // Taken on the next edge
         @(negedge clk);
      end
      access_in = 1'b0;
   endtask

   task automatic send_write(input logic [31:0] addr, input emesh_dmode_e dmode,
                             input logic [31:0] data);
      model_write(addr, dmode, data);
      send_packet(make_packet(1'b1, dmode, 4'h0, addr, data, 32'h0));
   endtask

   task automatic send_read(input logic [31:0] addr, input emesh_dmode_e dmode,
                            input logic [3:0] ctrl, input logic [31:0] src);
      // Response swaps the addresses and carries the whole word
      exp_q.push_back(make_packet(1'b1, DMODE_WORD, ctrl, src,
                                  model[word_index(addr)], addr));
      pending[word_index(addr)]++;
      send_packet(make_packet(1'b0, dmode, ctrl, addr, 32'h0, src));
   endtask

   task automatic wait_responses();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < RSP_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      assert (exp_q.size() == 0)
         else begin
            other_errors++;
            $display("Timed out waiting for %0d read responses", exp_q.size());
            exp_q.delete();
         end
   endtask

   //##########################################################################
   // Response monitor
   //##########################################################################

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else begin
            value_errors++;
            $display("Error at time %0t: response %s is %h, expected %h",
                     $time, name, got, exp);
         end
   endtask

   task automatic check_response(input logic [`EMESH_PW-1:0] got);
      logic [`EMESH_PW-1:0] exp;
      rsp_count++;
      assert (exp_q.size() != 0)
         else begin
            other_errors++;
            $display("A read response arrived when none was expected");
         end
      if (exp_q.size() != 0) begin
         exp = exp_q.pop_front();
         check_field("write flag", 32'(got[`EMESH_WR_BIT]), 32'(exp[`EMESH_WR_BIT]));
         check_field("datamode", 32'(got[`EMESH_DM_LSB +: 2]), 32'(exp[`EMESH_DM_LSB +: 2]));
         check_field("ctrlmode", 32'(got[`EMESH_CM_LSB +: 4]), 32'(exp[`EMESH_CM_LSB +: 4]));
         check_field("spare", 32'(got[`EMESH_DST_LSB-1]), 32'(exp[`EMESH_DST_LSB-1]));
         check_field("dstaddr", got[`EMESH_DST_LSB +: 32], exp[`EMESH_DST_LSB +: 32]);
         check_field("data", got[`EMESH_DAT_LSB +: 32], exp[`EMESH_DAT_LSB +: 32]);
         check_field("srcaddr", got[`EMESH_SRC_LSB +: 32], exp[`EMESH_SRC_LSB +: 32]);
         pending[word_index(exp[`EMESH_SRC_LSB +: 32])]--;   // Read address done
      end
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         if (held) begin
            assert (access_out === 1'b1 && packet_out === held_pkt)
               else begin
                  value_errors++;
                  $display("Error at time %0t: response changed while wait_in was high",
                           $time);
               end
         end
         if (access_out && !wait_in)
            check_response(packet_out);                  // Transfer on this edge
         held     = access_out && wait_in;
         held_pkt = packet_out;
      end
   end

   //##########################################################################
   // Directed tests
   //##########################################################################

   task automatic test_reset();
      assert (access_out === 1'b0 && wait_out === 1'b0)
         else begin
            value_errors++;
            $display("Error at time %0t: access_out %b wait_out %b after reset, expected 0 0",
                     $time, access_out, wait_out);
         end
   endtask

   task automatic test_word_rw();
      send_write(32'h0000_0040, DMODE_WORD, 32'hCAFE_F00D);
      send_read(32'h0000_0040, DMODE_WORD, 4'hA, 32'h8000_1234);
      wait_responses();
   endtask

   task automatic test_byte_merge();
      int i;
      for (i = 0; i < 4; i++)
         send_write(32'h0000_0080 + i, DMODE_BYTE, 32'h11 * (i + 1));  // One per lane
      send_write(32'h0000_0082, DMODE_HALF, 32'h0000_BEEF);            // Upper half
      send_read(32'h0000_0080, DMODE_WORD, 4'h5, 32'h8000_0080);
      wait_responses();
   endtask

   task automatic test_backpressure();
      int   i;
      int   j;
      int   n;
      logic rose;
      rose = 1'b0;
      n    = 0;
      for (i = 0; i < 4; i++)
         send_write(32'h0000_0100 + 4*i, DMODE_WORD, 32'hA5A5_0000 | i);
      wait_in = 1'b1;                                    // Output blocked
      fork
         for (j = 0; j < 12; j++)
            send_read(32'h0000_0100 + 4*(j % 4), DMODE_WORD, 4'(j), 32'h9000_0000 + j);
         begin
            while (!rose && n < 100) begin
               @(posedge clk);
               rose = wait_out;                          // Read queue backed up
               n++;
            end
            repeat (8) @(posedge clk);                   // Hold a while longer
            @(negedge clk);
            wait_in = 1'b0;
         end
      join
      assert (rose)
         else begin
            other_errors++;
            $display("wait_out never rose while wait_in was held high");
         end
      wait_responses();
   endtask

   task automatic test_random();
      int           i;
      int           reads;
      int           base_rsp;
      logic [31:0]  r;
      logic [31:0]  data;
      logic [31:0]  addr;
      emesh_dmode_e dmode;
      for (i = 0; i < 16; i++)
         send_write(32'h0000_1000 + 4*i, DMODE_WORD, $random(seed));   // Defined words
      reads     = 0;
      base_rsp  = rsp_count;
      rand_wait = 1'b1;
      for (i = 0; i < 200; i++) begin
         r     = $random(seed);
         data  = $random(seed);
         addr  = 32'h0000_1000 + 4*r[3:0] + r[5:4];      // 16 words, any lane
         dmode = emesh_dmode_e'(2'(r[9:8] % 2'd3));
         if (r[10] && pending[word_index(addr)] == 0)    // No write past a pending read
            send_write(addr, dmode, data);
         else begin
            send_read(addr, dmode, r[14:11], {16'h8000, r[31:16]});
            reads++;
         end
      end
      rand_wait = 1'b0;
      wait_in   = 1'b0;
      wait_responses();
      assert (rsp_count - base_rsp == reads)
         else begin
            value_errors++;
            $display("Error at time %0t: %0d responses for %0d reads",
                     $time, rsp_count - base_rsp, reads);
         end
   endtask

   //##########################################################################
   // Sequence and watchdog
   //##########################################################################

   initial begin
      rst       = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      repeat (10) @(negedge clk);                        // 10 edges in reset
      rst = 1'b0;
      @(negedge clk);
      test_reset();
      test_word_rw();
      test_byte_merge();
      test_backpressure();
      test_random();
      $display("Summary: %0d value errors, %0d other errors, %0d responses checked",
               value_errors, other_errors, rsp_count);
      if (value_errors + other_errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial begin
      #(WDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not complete", WDOG_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/emesh_pkg.sv
verilog/emesh_decoder.sv
verilog/emesh_fifo.sv
verilog/emesh_arbiter.sv
verilog/emesh_memory.sv
verilog/emesh_mem_top.sv
sim/emesh_mem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = emesh_mem_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
